//--- all.f
+incdir+hdl
hdl/fpu_aux_pkg.sv
hdl/fpu_i2f.sv
hdl/fpu_fmin_fmax.sv
hdl/fpu_float_aux.sv
hdl/fpu_aux_top.sv
test/fpu_aux_chk.sv
test/tb_fpu_aux.sv

//--- run.sh
#!/bin/sh
# Builds the auxiliary FPU testbench with Verilator and runs it.
# The exit status is zero only when the simulation passes.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_fpu_aux \
  -f all.f -o tb_fpu_aux &&
./obj_dir/tb_fpu_aux || exit 1
exit 0

//--- test/tb_fpu_aux.sv
/*
 * Random-stimulus testbench for the auxiliary FPU pipeline. Accepted requests
 * go into a scoreboard queue with the reference model's response, and every
 * output transfer is compared against the head of that queue.
 */

`timescale 1ns/1ps

`include "fpu_aux_defines.svh"

module tb_fpu_aux
  import fpu_aux_pkg::*;
();

  logic          clk;
  logic          arst_n;
  logic          in_v;
  fpu_aux_req_s  in_req;
  logic          in_ready;
  logic          out_v;
  fpu_aux_resp_s out_resp;
  logic          out_ready;

  logic [31:0]   rng_state;
  int            cycle;
  int            sent;
  int            checked;
  fpu_aux_resp_s exp_q[$];
  fpu_float_op_e op_q[$];
  int            acc_q[$];

  fpu_aux_top u_fpu_aux_top (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .in_v_i      (in_v),
    .in_req_i    (in_req),
    .in_ready_o  (in_ready),
    .out_v_o     (out_v),
    .out_resp_o  (out_resp),
    .out_ready_i (out_ready)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic stop_run(input string why);
    $display("Verification failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_result(input string name, input logic [`FPU_AUX_DATA_W-1:0] exp,
                              input logic [`FPU_AUX_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s: result expected %h, actual %h", name, exp, act);
      stop_run("result mismatch");
    end
  endtask

  task automatic check_fflags(input string name, input fflags_s exp, input fflags_s act);
    if (act !== exp) begin
      $display("FAILED %s: fflags expected %b, actual %b", name, exp, act);
      stop_run("fflags mismatch");
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("FAILED %s: latency expected %0d, actual %0d", name, exp, act);
      stop_run("latency mismatch");
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: in_ready expected %b, actual %b", name, exp, act);
      stop_run("input ready mismatch");
    end
  endtask

  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic is_snan(input logic [31:0] x);
    return is_nan(x) && !x[22];
  endfunction

  // Maps sign-magnitude order onto unsigned order, -0 just below +0
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : (x | 32'h8000_0000);
  endfunction

  function automatic fpu_aux_resp_s model_minmax(input logic [31:0] a, input logic [31:0] b,
                                                 input logic want_min);
    fpu_aux_resp_s r;
    logic          pick_a;
    r = '0;
    r.fflags.invalid = is_snan(a) || is_snan(b);
    pick_a = want_min ? (order_key(a) <= order_key(b)) : (order_key(a) >= order_key(b));
    if (is_nan(a) && is_nan(b)) begin
      r.result = `FPU_AUX_CANON_NAN;
    end else if (is_nan(a)) begin
      r.result = b;
    end else if (is_nan(b)) begin
      r.result = a;
    end else begin
      r.result = pick_a ? a : b;
    end
    return r;
  endfunction

  function automatic fpu_aux_resp_s model_i2f(input logic [31:0] x, input logic sgn,
                                              input frm_e rm);
    fpu_aux_resp_s r;
    logic          neg;
    logic          up;
    logic [63:0]   mag;
    logic [63:0]   kept;
    logic [63:0]   rem;
    logic [63:0]   half;
    int            e;
    int            sh;
    r = '0;
    neg = sgn && x[31];
    mag = {32'd0, neg ? (32'd0 - x) : x};
    if (mag == 64'd0) begin
      return r;
    end
    e = 31;
    while (!mag[e]) begin
      e--;
    end
    sh = (e > 23) ? e - 23 : 0;
    kept = (e < 23) ? (mag << (23 - e)) : (mag >> sh);
    rem = mag - ((mag >> sh) << sh);
    half = (sh > 0) ? (64'd1 << (sh - 1)) : 64'd0;
    case (rm)
      eRTZ: up = 1'b0;
      eRDN: up = neg && (rem != 64'd0);
      eRUP: up = !neg && (rem != 64'd0);
      eRMM: up = (sh > 0) && (rem >= half);
      default: up = (rem > half) || ((sh > 0) && (rem == half) && kept[0]);
    endcase
    kept = kept + {63'd0, up};
    if (kept[24]) begin
      kept = kept >> 1;
      e++;
    end
    r.result = {neg, 8'(`FPU_AUX_BIAS + e), kept[22:0]};
    r.fflags.inexact = (rem != 64'd0);
    return r;
  endfunction

  function automatic fpu_aux_resp_s model_resp(input fpu_aux_req_s q);
    fpu_aux_resp_s r;
    r = '0;
    r.result = q.rs1;
    case (q.op)
      eFCVT_S_W:  r = model_i2f(q.rs1, 1'b1, q.rm);
      eFCVT_S_WU: r = model_i2f(q.rs1, 1'b0, q.rm);
      eFMIN:      r = model_minmax(q.rs1, q.rs2, 1'b1);
      eFMAX:      r = model_minmax(q.rs1, q.rs2, 1'b0);
      eFSGNJ:     r.result[31] = q.rs2[31];
      eFSGNJN:    r.result[31] = ~q.rs2[31];
      eFSGNJX:    r.result[31] = q.rs1[31] ^ q.rs2[31];
      default:    r.result = q.rs1;
    endcase
    return r;
  endfunction

  // Leans on zeros, NaNs, infinities and integer corner values
  function automatic logic [31:0] random_operand();
    logic [31:0] r;
    logic [31:0] k;
    r = xorshift32();
    k = xorshift32();
    case (k[2:0])
      3'd0: return {r[31], 31'd0};
      3'd1: return {r[31], 8'hff, 1'b1, r[21:0]};
      3'd2: return {r[31], 8'hff, 1'b0, r[21:1], 1'b1};
      3'd3: return {r[31], 8'hff, 23'd0};
      3'd4: begin
        case (r[1:0])
          2'd0: return 32'h8000_0000;
          2'd1: return 32'h7fff_ffff;
          2'd2: return 32'h0100_0001;
          default: return 32'hffff_ffff;
        endcase
      end
      3'd5: return {{24{r[31]}}, r[7:0]};
      default: return r;
    endcase
  endfunction

  function automatic fpu_aux_req_s random_request();
    fpu_aux_req_s q;
    logic [31:0]  k;
    k = xorshift32();
    q.op = fpu_float_op_e'(k[2:0]);
    q.rm = frm_e'(3'(k[31:8] % 24'd5));
    q.rs1 = random_operand();
    q.rs2 = random_operand();
    return q;
  endfunction

  // One clock edge: score the transfers of this edge, then drive the next inputs
  task automatic clock_step(input bit full_rate, input int target);
    fpu_float_op_e op;
    string         name;
    logic [31:0]   k;
    @(posedge clk);
    cycle++;
    // Input is refused only with both stages full and the output stalled
    check_ready($sformatf("in_ready @%0d", cycle),
                (exp_q.size() < 2) || out_ready, in_ready);
    if (out_v && out_ready) begin
      if (exp_q.size() == 0) begin
        stop_run("a response came out with no request outstanding");
      end else begin
        op = op_q.pop_front();
        name = $sformatf("%s #%0d", op.name(), checked);
        check_result(name, exp_q[0].result, out_resp.result);
        check_fflags(name, exp_q[0].fflags, out_resp.fflags);
        if (full_rate) begin
          check_latency(name, 2, cycle - acc_q[0]);
        end
        void'(exp_q.pop_front());
        void'(acc_q.pop_front());
        checked++;
      end
    end
    if (in_v && in_ready) begin
      exp_q.push_back(model_resp(in_req));
      op_q.push_back(in_req.op);
      acc_q.push_back(cycle);
      sent++;
    end
    if (!in_v || in_ready) begin
      k = xorshift32();
      in_v <= (sent < target) && (full_rate || k[1:0] != 2'd0);
      in_req <= random_request();
    end
    k = xorshift32();
    out_ready <= full_rate || k[0];
  endtask

  task automatic run_phase(input bit full_rate, input int target);
    int waited;
    sent = 0;
    waited = 0;
    while (sent < target && waited < target * 8) begin
      clock_step(full_rate, target);
      waited++;
    end
    if (sent < target) begin
      stop_run("timed out waiting for requests to be accepted");
    end else begin
      waited = 0;
      while (exp_q.size() != 0 && waited < 200) begin
        clock_step(full_rate, target);
        waited++;
      end
      if (exp_q.size() != 0) begin
        stop_run("timed out waiting for outstanding responses");
      end else begin
        // Idle edges after the drain catch any response beyond the last one
        repeat (8) begin
          clock_step(full_rate, target);
        end
      end
    end
  endtask

  initial begin
    rng_state = 32'h9205_c019;
    clk = 1'b0;
    arst_n = 1'b0;
    in_v = 1'b0;
    in_req = '0;
    out_ready = 1'b0;
    cycle = 0;
    checked = 0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    if (out_v !== 1'b0 || in_ready !== 1'b1) begin
      stop_run("after reset the output is valid or the input is not ready");
    end
    // Full rate first, so the fixed latency can be checked
    run_phase(1'b1, 300);
    run_phase(1'b0, 700);
    $display("Verification passed");
    $finish;
  end

endmodule

//--- test/fpu_aux_chk.sv
/*
 * Concurrent assertions on the auxiliary FPU handshakes and flags.
 * Bound into the top level, so every instance of it is watched.
 */

`timescale 1ns/1ps

module fpu_aux_chk
  import fpu_aux_pkg::*;
(
  input logic          clk_i,
  input logic          arst_n_i,
  input logic          in_v_i,
  input fpu_aux_req_s  in_req_i,
  input logic          in_ready_o,
  input logic          out_v_o,
  input fpu_aux_resp_s out_resp_o,
  input logic          out_ready_i
);

  // A stalled response stays valid and unchanged until it is taken
  property p_out_hold;
    @(posedge clk_i) disable iff (!arst_n_i)
      out_v_o && !out_ready_i |=> out_v_o && $stable(out_resp_o);
  endproperty

  // None of these operations can divide, overflow or underflow
  property p_no_range_flags;
    @(posedge clk_i) disable iff (!arst_n_i)
      out_v_o |-> !(out_resp_o.fflags.div_zero | out_resp_o.fflags.overflow |
                    out_resp_o.fflags.underflow);
  endproperty

  // Guards the upstream driver: a pending request is held as it is
  property p_in_hold;
    @(posedge clk_i) disable iff (!arst_n_i)
      in_v_i && !in_ready_o |=> in_v_i && $stable(in_req_i);
  endproperty

  a_out_hold: assert property (p_out_hold)
    else $error("response dropped or changed while the output was stalled");
  a_no_range_flags: assert property (p_no_range_flags)
    else $error("div_zero, overflow or underflow flag raised");
  a_in_hold: assert property (p_in_hold)
    else $error("request dropped or changed before it was accepted");

endmodule

bind fpu_aux_top fpu_aux_chk u_fpu_aux_chk (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .in_v_i      (in_v_i),
  .in_req_i    (in_req_i),
  .in_ready_o  (in_ready_o),
  .out_v_o     (out_v_o),
  .out_resp_o  (out_resp_o),
  .out_ready_i (out_ready_i)
);

//--- hdl/fpu_aux_top.sv
/*
 * Auxiliary FPU with a two-stage valid/ready pipeline. Requests are
 * registered in stage 1, evaluated, and the response is registered in
 * stage 2, giving two cycles of latency and one result per cycle.
 */

`timescale 1ns/1ps

module fpu_aux_top
  import fpu_aux_pkg::*;
(
  input  logic          clk_i,
  input  logic          arst_n_i,

  input  logic          in_v_i,
  input  fpu_aux_req_s  in_req_i,
  output logic          in_ready_o,

  output logic          out_v_o,
  output fpu_aux_resp_s out_resp_o,
  input  logic          out_ready_i
);

  logic          s1_v;
  fpu_aux_req_s  s1_req;
  logic          s2_v;
  fpu_aux_resp_s s2_resp;

  logic          s2_load;
  logic          s1_adv;
  logic          in_fire;
  fpu_aux_resp_s core_resp;

  // Stage 2 takes a new item when empty or when its current one leaves
  assign s2_load = ~s2_v | out_ready_i;
  assign s1_adv  = s1_v & s2_load;

  assign in_ready_o = ~s1_v | s2_load;
  assign in_fire    = in_v_i & in_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_v <= 1'b0;
    end else if (in_ready_o) begin
      s1_v <= in_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      s1_req <= in_req_i;
    end
  end

  fpu_float_aux u_fpu_float_aux (
    .req_i  (s1_req),
    .resp_o (core_resp)
  );

  // An empty stage 1 moving forward leaves stage 2 empty as well
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s2_v <= 1'b0;
    end else if (s2_load) begin
      s2_v <= s1_v;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_adv) begin
      s2_resp <= core_resp;
    end
  end

  assign out_v_o    = s2_v;
  assign out_resp_o = s2_resp;

endmodule

//--- hdl/fpu_float_aux.sv
/*
 * Combinational core of the auxiliary FPU. Decodes the op, runs the
 * converter and min/max units, does sign injection and FMV.W.X itself
 * and selects the response.
 */

`timescale 1ns/1ps

`include "fpu_aux_defines.svh"

module fpu_float_aux
  import fpu_aux_pkg::*;
(
  input  fpu_aux_req_s  req_i,
  output fpu_aux_resp_s resp_o
);

  logic is_fcvt_s_w;
  logic is_fmin;

  logic [`FPU_AUX_DATA_W-1:0] i2f_result;
  fflags_s                    i2f_fflags;

  logic [`FPU_AUX_DATA_W-1:0] minmax_result;
  logic                       minmax_invalid;

  logic [`FPU_AUX_DATA_W-1:0] sgnj_result;
  logic                       rs1_sign;
  logic                       rs2_sign;

  assign is_fcvt_s_w = (req_i.op == eFCVT_S_W);
  assign is_fmin     = (req_i.op == eFMIN);

  fpu_i2f u_i2f (
    .int_i    (req_i.rs1),
    .signed_i (is_fcvt_s_w),
    .rm_i     (req_i.rm),
    .result_o (i2f_result),
    .fflags_o (i2f_fflags)
  );

  fpu_fmin_fmax u_fmin_fmax (
    .rs1_i         (req_i.rs1),
    .rs2_i         (req_i.rs2),
    .min_not_max_i (is_fmin),
    .result_o      (minmax_result),
    .invalid_o     (minmax_invalid)
  );

  assign rs1_sign = req_i.rs1[`FPU_AUX_DATA_W-1];
  assign rs2_sign = req_i.rs2[`FPU_AUX_DATA_W-1];

  // Magnitude always comes from rs1; FMV.W.X keeps rs1's own sign
  always_comb begin
    sgnj_result = req_i.rs1;
    case (req_i.op)
      eFSGNJ: begin
        sgnj_result[`FPU_AUX_DATA_W-1] = rs2_sign;
      end
      eFSGNJN: begin
        sgnj_result[`FPU_AUX_DATA_W-1] = ~rs2_sign;
      end
      eFSGNJX: begin
        sgnj_result[`FPU_AUX_DATA_W-1] = rs1_sign ^ rs2_sign;
      end
      default: begin
        sgnj_result[`FPU_AUX_DATA_W-1] = rs1_sign;
      end
    endcase
  end

  always_comb begin
    case (req_i.op)
      eFMIN, eFMAX: begin
        resp_o.result = minmax_result;
        resp_o.fflags = '{
          invalid:   minmax_invalid,
          div_zero:  1'b0,
          overflow:  1'b0,
          underflow: 1'b0,
          inexact:   1'b0
        };
      end
      eFCVT_S_W, eFCVT_S_WU: begin
        resp_o.result = i2f_result;
        resp_o.fflags = i2f_fflags;
      end
      // Sign injection and FMV.W.X never raise a flag
      default: begin
        resp_o.result = sgnj_result;
        resp_o.fflags = '0;
      end
    endcase
  end

endmodule

//--- hdl/fpu_fmin_fmax.sv
/*
 * Combinational FMIN and FMAX on binary32 operands, following the
 * RISC-V rules for NaNs and for -0 against +0.
 */

`timescale 1ns/1ps

`include "fpu_aux_defines.svh"

module fpu_fmin_fmax (
  input  logic [`FPU_AUX_DATA_W-1:0] rs1_i,
  input  logic [`FPU_AUX_DATA_W-1:0] rs2_i,
  input  logic                       min_not_max_i,
  output logic [`FPU_AUX_DATA_W-1:0] result_o,
  output logic                       invalid_o
);

  logic a_nan;
  logic b_nan;
  logic a_snan;
  logic b_snan;
  logic a_sign;
  logic b_sign;
  logic a_lt_b;
  logic [`FPU_AUX_DATA_W-2:0] a_mag;
  logic [`FPU_AUX_DATA_W-2:0] b_mag;

  assign a_sign = rs1_i[`FPU_AUX_DATA_W-1];
  assign b_sign = rs2_i[`FPU_AUX_DATA_W-1];
  assign a_mag  = rs1_i[`FPU_AUX_DATA_W-2:0];
  assign b_mag  = rs2_i[`FPU_AUX_DATA_W-2:0];

  assign a_nan = (&rs1_i[`FPU_AUX_DATA_W-2 -: `FPU_AUX_EXP_W]) &
                 (|rs1_i[`FPU_AUX_SIG_W-2:0]);
  assign b_nan = (&rs2_i[`FPU_AUX_DATA_W-2 -: `FPU_AUX_EXP_W]) &
                 (|rs2_i[`FPU_AUX_SIG_W-2:0]);

  // Signaling when the quiet bit is clear
  assign a_snan = a_nan & ~rs1_i[`FPU_AUX_SIG_W-2];
  assign b_snan = b_nan & ~rs2_i[`FPU_AUX_SIG_W-2];

  // Sign-magnitude order, so -0 sorts below +0
  always_comb begin
    if (a_sign != b_sign) begin
      a_lt_b = a_sign;
    end else if (a_sign) begin
      a_lt_b = a_mag > b_mag;
    end else begin
      a_lt_b = a_mag < b_mag;
    end
  end

  always_comb begin
    if (a_nan & b_nan) begin
      result_o = `FPU_AUX_CANON_NAN;
    end else if (a_nan) begin
      result_o = rs2_i;
    end else if (b_nan) begin
      result_o = rs1_i;
    end else if (min_not_max_i) begin
      result_o = a_lt_b ? rs1_i : rs2_i;
    end else begin
      result_o = a_lt_b ? rs2_i : rs1_i;
    end
  end

  assign invalid_o = a_snan | b_snan;

endmodule

//--- hdl/fpu_i2f.sv
/*
 * Combinational 32-bit integer to binary32 conversion for FCVT.S.W and
 * FCVT.S.WU. Rounds by the RISC-V mode and reports inexact.
 */

`timescale 1ns/1ps

`include "fpu_aux_defines.svh"

module fpu_i2f
  import fpu_aux_pkg::*;
(
  input  logic [`FPU_AUX_DATA_W-1:0] int_i,
  input  logic                       signed_i,
  input  frm_e                       rm_i,
  output logic [`FPU_AUX_DATA_W-1:0] result_o,
  output fflags_s                    fflags_o
);

  localparam logic [`FPU_AUX_EXP_W-1:0] bias_lp = `FPU_AUX_BIAS;

  logic                       neg;
  logic [`FPU_AUX_DATA_W-1:0] mag;
  logic [4:0]                 msb;
  logic [`FPU_AUX_DATA_W-1:0] norm;
  logic [`FPU_AUX_SIG_W-1:0]  sig;
  logic                       guard;
  logic                       sticky;
  logic                       round_up;
  logic [`FPU_AUX_SIG_W:0]    sig_rnd;
  logic                       carry;
  logic [`FPU_AUX_EXP_W-1:0]  exp_raw;
  logic [`FPU_AUX_EXP_W-1:0]  exp_rnd;
  logic [`FPU_AUX_SIG_W-2:0]  frac;
  logic                       is_zero;

  // The most negative integer negates to itself, which is the right magnitude
  assign neg     = signed_i & int_i[`FPU_AUX_DATA_W-1];
  assign mag     = neg ? (~int_i + 1'b1) : int_i;
  assign is_zero = (mag == '0);

  // Priority encoder, highest set bit wins
  always_comb begin
    msb = '0;
    for (int i = 0; i < `FPU_AUX_DATA_W; i++) begin
      if (mag[i]) begin
        msb = 5'(i);
      end
    end
  end

  // Leading one lands on the top bit; what falls below the significand
  // becomes guard and sticky
  assign norm   = mag << (5'd31 - msb);
  assign sig    = norm[`FPU_AUX_DATA_W-1 -: `FPU_AUX_SIG_W];
  assign guard  = norm[`FPU_AUX_DATA_W-`FPU_AUX_SIG_W-1];
  assign sticky = |norm[`FPU_AUX_DATA_W-`FPU_AUX_SIG_W-2:0];

  always_comb begin
    case (rm_i)
      eRTZ: begin
        round_up = 1'b0;
      end
      eRDN: begin
        round_up = neg & (guard | sticky);
      end
      eRUP: begin
        round_up = ~neg & (guard | sticky);
      end
      eRMM: begin
        round_up = guard;
      end
      // RNE, and the reserved codes fall back to it
      default: begin
        round_up = guard & (sticky | sig[0]);
      end
    endcase
  end

  assign sig_rnd = {1'b0, sig} + {{`FPU_AUX_SIG_W{1'b0}}, round_up};
  assign carry   = sig_rnd[`FPU_AUX_SIG_W];
  assign exp_raw = bias_lp + {3'd0, msb};

  // A carry out of the significand bumps the exponent, fraction goes to zero
  assign exp_rnd = exp_raw + {{(`FPU_AUX_EXP_W-1){1'b0}}, carry};
  assign frac    = carry ? sig_rnd[`FPU_AUX_SIG_W-1:1] : sig_rnd[`FPU_AUX_SIG_W-2:0];

  assign result_o = is_zero ? '0 : {neg, exp_rnd, frac};

  assign fflags_o = '{
    invalid:   1'b0,
    div_zero:  1'b0,
    overflow:  1'b0,
    underflow: 1'b0,
    inexact:   guard | sticky
  };

endmodule

//--- hdl/fpu_aux_pkg.sv
/*
 * Types shared by the auxiliary FPU and its testbench: opcodes,
 * rounding modes, exception flags and the request and response words.
 */

`include "fpu_aux_defines.svh"

package fpu_aux_pkg;

  // All eight codes are in use, so every op value is legal
  typedef enum logic [2:0] {
    eFCVT_S_W  = 3'd0,
    eFCVT_S_WU = 3'd1,
    eFMIN      = 3'd2,
    eFMAX      = 3'd3,
    eFSGNJ     = 3'd4,
    eFSGNJN    = 3'd5,
    eFSGNJX    = 3'd6,
    eFMV_W_X   = 3'd7
  } fpu_float_op_e;

  // RISC-V frm encoding; codes 5 to 7 are reserved
  typedef enum logic [2:0] {
    eRNE = 3'd0,
    eRTZ = 3'd1,
    eRDN = 3'd2,
    eRUP = 3'd3,
    eRMM = 3'd4
  } frm_e;

  typedef struct packed {
    logic invalid;
    logic div_zero;
    logic overflow;
    logic underflow;
    logic inexact;
  } fflags_s;

  typedef struct packed {
    fpu_float_op_e              op;
    frm_e                       rm;
    logic [`FPU_AUX_DATA_W-1:0] rs1;
    logic [`FPU_AUX_DATA_W-1:0] rs2;
  } fpu_aux_req_s;

  typedef struct packed {
    logic [`FPU_AUX_DATA_W-1:0] result;
    fflags_s                    fflags;
  } fpu_aux_resp_s;

endpackage

//--- hdl/fpu_aux_defines.svh
/*
 * Fixed binary32 and RV32 dimensions for the auxiliary FPU.
 * Included by the package and by any module that slices float fields.
 */

`ifndef FPU_AUX_DEFINES_SVH
`define FPU_AUX_DEFINES_SVH

// Operand and result width, one RV32 register
`define FPU_AUX_DATA_W 32

// Exponent width and significand width, hidden bit included
`define FPU_AUX_EXP_W 8
`define FPU_AUX_SIG_W 24

`define FPU_AUX_BIAS 127

// Positive quiet NaN with only the top fraction bit set
`define FPU_AUX_CANON_NAN 32'h7fc0_0000

`endif
